/* parser_testdata.txt */
00112233445566778899aabb0800450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 1 1 1 0 001 01 1 003c c0a80001 c0a80002 1f90 0050 1 012
00112233445566778899aabb0800450005dcabcd000080061a2b0a0000010a0000fec35001bbdeadbeefcafef00d81180200000000000102030405060708090a 1 1 1 1 1 1ff 1f 1 05a8 0a000001 0a0000fe c350 01bb 1 118
00112233445566778899aabb0800450000300001000040110000ac100005ac10000a0035d431001c0000a0a1a2a3a4a5a6a7a8a9aaabacadaeafb0b1b2b3b4b5 1 1 1 1 0 002 02 1 0014 ac100005 ac10000a 0035 d431 2 0a5
00112233445566778899aabb0800450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 1 1 0 0 010 01 0 0000 00000000 00000000 0000 0000 0 000
00112233445566778899aabb86dd450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 1 1 1 0 003 01 1 0000 c0a80001 c0a80002 1f90 0050 0 012
00112233445566778899aabb0800650000300001000040110000ac100005ac10000a0035d431001c0000a0a1a2a3a4a5a6a7a8a9aaabacadaeafb0b1b2b3b4b5 1 1 1 1 1 004 01 1 0000 ac100005 ac10000a 0035 d431 0 0a5
00112233445566778899aabb0800460000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 1 1 1 0 005 01 1 0000 c0a80001 c0a80002 1f90 0050 0 012
00112233445566778899aabb0800450000641234400040010000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 1 1 1 0 006 01 1 0000 c0a80001 c0a80002 1f90 0050 0 012
00112233445566778899aabb0800450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 0 1 1 0 011 02 0 0000 00000000 00000000 0000 0000 0 000
00112233445566778899aabb0800450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 0 1 1 1 0 012 02 0 0000 00000000 00000000 0000 0000 0 000
00112233445566778899aabb0800450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 1 0 1 0 013 01 0 0000 00000000 00000000 0000 0000 0 000
00112233445566778899aabb0800450000300001000040110000ac100005ac10000a0035d431001c0000a0a1a2a3a4a5a6a7a8a9aaabacadaeafb0b1b2b3b4b5 1 1 1 1 1 0a5 03 1 0014 ac100005 ac10000a 0035 d431 2 0a5
00112233445566778899aabb0800450005dcabcd000080061a2b0a0000010a0000fec35001bbdeadbeefcafef00d81180200000000000102030405060708090a 1 1 1 1 0 100 10 1 05a8 0a000001 0a0000fe c350 01bb 1 118
00112233445566778899aabb0800450000300001000040110000ac100005ac10000a0035d431001c0000a0a1a2a3a4a5a6a7a8a9aaabacadaeafb0b1b2b3b4b5 1 1 1 0 0 014 01 0 0000 00000000 00000000 0000 0000 0 000
00112233445566778899aabb0800450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 1 1 1 1 1 0ff 07 1 003c c0a80001 c0a80002 1f90 0050 1 012
00112233445566778899aabb0800450000641234400040060000c0a80001c0a800021f90005000000001000000005012ffff00000000f0f1f2f3f4f5f6f7f8f9 0 0 0 1 0 015 01 0 0000 00000000 00000000 0000 0000 0 000
00112233445566778899aabb0800450000300001000040110000ac100005ac10000a0035d431001c0000a0a1a2a3a4a5a6a7a8a9aaabacadaeafb0b1b2b3b4b5 1 1 1 1 0 042 04 1 0014 ac100005 ac10000a 0035 d431 2 0a5

/* flist.f */
parser_pkg.sv
l3_fields_if.sv
l4_fields_if.sv
ipv4_header_parser.sv
l4_header_parser.sv
meta_builder.sv
pkt_parser_top.sv
parser_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the header parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module parser_tb -o parser_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/parser_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Testbench run completed without failure"
exit 0

/* parser_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module parser_tb;

    localparam int MAX_VEC = 64;

    logic                   clk = 1'b0;
    logic                   rst;
    parser_pkg::pkt_data_t  in_pkt_data;
    logic                   in_pkt_valid;
    logic                   in_pkt_sop;
    logic                   in_pkt_eop;
    parser_pkg::pkt_empty_t in_pkt_empty;
    logic                   in_pkt_ready;
    parser_pkg::pkt_id_t    in_meta_pkt_id;
    parser_pkg::flit_cnt_t  in_meta_flits;
    logic                   in_meta_valid;
    logic                   in_meta_ready;
    logic                   disable_pcie;
    logic                   out_meta_valid;
    logic                   out_meta_ready;
    parser_pkg::pkt_len_t   out_len;
    parser_pkg::ip_addr_t   out_sip;
    parser_pkg::ip_addr_t   out_dip;
    parser_pkg::l4_port_t   out_sport;
    parser_pkg::l4_port_t   out_dport;
    parser_pkg::prot_code_t out_prot;
    parser_pkg::tcp_flags_t out_tcp_flags;
    parser_pkg::pkt_id_t    out_pkt_id;
    parser_pkg::flit_cnt_t  out_flits;
    logic                   out_pcie;

    // One entry per line of the data file
    parser_pkg::pkt_data_t  vec_beat      [0:MAX_VEC-1];
    logic                   vec_sop       [0:MAX_VEC-1];
    logic                   vec_eop       [0:MAX_VEC-1];
    logic                   vec_mval      [0:MAX_VEC-1];
    logic                   vec_ready     [0:MAX_VEC-1];
    logic                   vec_dis       [0:MAX_VEC-1];
    parser_pkg::pkt_id_t    vec_id        [0:MAX_VEC-1];
    parser_pkg::flit_cnt_t  vec_flits     [0:MAX_VEC-1];
    logic                   vec_exp_valid [0:MAX_VEC-1];
    parser_pkg::pkt_len_t   vec_len       [0:MAX_VEC-1];
    parser_pkg::ip_addr_t   vec_sip       [0:MAX_VEC-1];
    parser_pkg::ip_addr_t   vec_dip       [0:MAX_VEC-1];
    parser_pkg::l4_port_t   vec_sport     [0:MAX_VEC-1];
    parser_pkg::l4_port_t   vec_dport     [0:MAX_VEC-1];
    parser_pkg::prot_code_t vec_prot      [0:MAX_VEC-1];
    parser_pkg::tcp_flags_t vec_flags     [0:MAX_VEC-1];

    int   n_vec = 0;
    int   timeout_limit = 1000;
    int   cycle_count = 0;
    logic pend_valid = 1'b0;
    int   pend_idx = 0;

    pkt_parser_top pkt_parser_top_i (
        .clk            (clk),
        .rst            (rst),
        .in_pkt_data    (in_pkt_data),
        .in_pkt_valid   (in_pkt_valid),
        .in_pkt_sop     (in_pkt_sop),
        .in_pkt_eop     (in_pkt_eop),
        .in_pkt_empty   (in_pkt_empty),
        .in_pkt_ready   (in_pkt_ready),
        .in_meta_pkt_id (in_meta_pkt_id),
        .in_meta_flits  (in_meta_flits),
        .in_meta_valid  (in_meta_valid),
        .in_meta_ready  (in_meta_ready),
        .disable_pcie   (disable_pcie),
        .out_meta_valid (out_meta_valid),
        .out_meta_ready (out_meta_ready),
        .out_len        (out_len),
        .out_sip        (out_sip),
        .out_dip        (out_dip),
        .out_sport      (out_sport),
        .out_dport      (out_dport),
        .out_prot       (out_prot),
        .out_tcp_flags  (out_tcp_flags),
        .out_pkt_id     (out_pkt_id),
        .out_flits      (out_flits),
        .out_pcie       (out_pcie)
    );

    always #5 clk = ~clk;

    // Watchdog on the total cycle count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout reached");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %0h, expected %0h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic load_vectors();
        int                     fd;
        int                     r;
        parser_pkg::pkt_data_t  f_beat;
        logic                   f_sop;
        logic                   f_eop;
        logic                   f_mval;
        logic                   f_ready;
        logic                   f_dis;
        parser_pkg::pkt_id_t    f_id;
        parser_pkg::flit_cnt_t  f_flits;
        logic                   f_exp_valid;
        parser_pkg::pkt_len_t   f_len;
        parser_pkg::ip_addr_t   f_sip;
        parser_pkg::ip_addr_t   f_dip;
        parser_pkg::l4_port_t   f_sport;
        parser_pkg::l4_port_t   f_dport;
        parser_pkg::prot_code_t f_prot;
        parser_pkg::tcp_flags_t f_flags;
        fd = $fopen("parser_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file parser_testdata.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "Missing vector file");
        end
        r = 16;
        while (r == 16 && n_vec < MAX_VEC) begin
            r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
                        f_beat, f_sop, f_eop, f_mval, f_ready, f_dis, f_id, f_flits,
                        f_exp_valid, f_len, f_sip, f_dip, f_sport, f_dport, f_prot,
                        f_flags);
            if (r == 16) begin
                vec_beat[n_vec]      = f_beat;
                vec_sop[n_vec]       = f_sop;
                vec_eop[n_vec]       = f_eop;
                vec_mval[n_vec]      = f_mval;
                vec_ready[n_vec]     = f_ready;
                vec_dis[n_vec]       = f_dis;
                vec_id[n_vec]        = f_id;
                vec_flits[n_vec]     = f_flits;
                vec_exp_valid[n_vec] = f_exp_valid;
                vec_len[n_vec]       = f_len;
                vec_sip[n_vec]       = f_sip;
                vec_dip[n_vec]       = f_dip;
                vec_sport[n_vec]     = f_sport;
                vec_dport[n_vec]     = f_dport;
                vec_prot[n_vec]      = f_prot;
                vec_flags[n_vec]     = f_flags;
                n_vec = n_vec + 1;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        in_pkt_valid   = 1'b0;
        in_pkt_sop     = 1'b0;
        in_pkt_eop     = 1'b0;
        in_meta_valid  = 1'b0;
        out_meta_ready = 1'b1;
    endtask

    task automatic drive_vector(input int idx);
        in_pkt_data    = vec_beat[idx];
        in_pkt_valid   = 1'b1;
        in_pkt_sop     = vec_sop[idx];
        in_pkt_eop     = vec_eop[idx];
        in_meta_valid  = vec_mval[idx];
        in_meta_pkt_id = vec_id[idx];
        in_meta_flits  = vec_flits[idx];
        disable_pcie   = vec_dis[idx];
        out_meta_ready = vec_ready[idx];
    endtask

    // Response to whatever was driven in the previous cycle
    task automatic check_outputs();
        if (pend_valid) begin
            check_val("out_meta_valid", 32'(out_meta_valid), 32'(vec_exp_valid[pend_idx]));
            if (vec_exp_valid[pend_idx]) begin
                check_val("out_prot", 32'(out_prot), 32'(vec_prot[pend_idx]));
                check_val("out_sip", out_sip, vec_sip[pend_idx]);
                check_val("out_dip", out_dip, vec_dip[pend_idx]);
                check_val("out_sport", 32'(out_sport), 32'(vec_sport[pend_idx]));
                check_val("out_dport", 32'(out_dport), 32'(vec_dport[pend_idx]));
                check_val("out_tcp_flags", 32'(out_tcp_flags), 32'(vec_flags[pend_idx]));
                check_val("out_pkt_id", 32'(out_pkt_id), 32'(vec_id[pend_idx]));
                check_val("out_flits", 32'(out_flits), 32'(vec_flits[pend_idx]));
                check_val("out_pcie", 32'(out_pcie), 32'(!vec_dis[pend_idx]));
                // Length only has a meaning for supported packets
                if (vec_prot[pend_idx] != parser_pkg::PROT_NS) begin
                    check_val("out_len", 32'(out_len), 32'(vec_len[pend_idx]));
                end
            end
        end else begin
            check_val("out_meta_valid when idle", 32'(out_meta_valid), 32'd0);
        end
        pend_valid = 1'b0;
    endtask

    task automatic run_vectors(input logic with_gaps);
        int gap;
        for (int i = 0; i < n_vec; i++) begin
            gap = with_gaps ? int'($urandom % 4) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
                check_outputs();
                drive_idle();
            end
            @(posedge clk);
            #1;
            check_outputs();
            drive_vector(i);
            #1;
            check_val("in_pkt_ready", 32'(in_pkt_ready), 32'(vec_ready[i]));
            check_val("in_meta_ready", 32'(in_meta_ready), 32'(vec_ready[i]));
            pend_valid = 1'b1;
            pend_idx   = i;
        end
    endtask

    initial begin
        rst            = 1'b1;
        in_pkt_data    = '0;
        in_pkt_valid   = 1'b0;
        in_pkt_sop     = 1'b0;
        in_pkt_eop     = 1'b0;
        in_pkt_empty   = '0;
        in_meta_pkt_id = '0;
        in_meta_flits  = '0;
        in_meta_valid  = 1'b0;
        disable_pcie   = 1'b0;
        out_meta_ready = 1'b1;
        void'($urandom(32'h7955));
        load_vectors();
        if (n_vec == 0) begin
            $display("The vector file holds no usable lines");
            $display("Simulation finished: FAIL");
            $fatal(1, "No vectors");
        end
        timeout_limit = n_vec * 6 + 50;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_val("out_meta_valid after reset", 32'(out_meta_valid), 32'd0);
        // First pass with random idle gaps, second pass back to back
        run_vectors(1'b1);
        run_vectors(1'b0);
        @(posedge clk);
        #1;
        check_outputs();
        drive_idle();
        @(posedge clk);
        #1;
        check_outputs();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* pkt_parser_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Header parser top level for single-beat packets
module pkt_parser_top (
    input  logic                     clk,
    input  logic                     rst,
    input  parser_pkg::pkt_data_t    in_pkt_data,
    input  logic                     in_pkt_valid,
    input  logic                     in_pkt_sop,
    input  logic                     in_pkt_eop,
    input  parser_pkg::pkt_empty_t   in_pkt_empty,
    output logic                     in_pkt_ready,
    input  parser_pkg::pkt_id_t      in_meta_pkt_id,
    input  parser_pkg::flit_cnt_t    in_meta_flits,
    input  logic                     in_meta_valid,
    output logic                     in_meta_ready,
    input  logic                     disable_pcie,
    output logic                     out_meta_valid,
    input  logic                     out_meta_ready,
    output parser_pkg::pkt_len_t     out_len,
    output parser_pkg::ip_addr_t     out_sip,
    output parser_pkg::ip_addr_t     out_dip,
    output parser_pkg::l4_port_t     out_sport,
    output parser_pkg::l4_port_t     out_dport,
    output parser_pkg::prot_code_t   out_prot,
    output parser_pkg::tcp_flags_t   out_tcp_flags,
    output parser_pkg::pkt_id_t      out_pkt_id,
    output parser_pkg::flit_cnt_t    out_flits,
    output logic                     out_pcie
);

    // Header fields sit at fixed offsets so in_pkt_empty goes unused

    l3_fields_if l3_fields ();
    l4_fields_if l4_fields ();

    // Input side stalls exactly when the metadata sink does
    assign in_pkt_ready  = out_meta_ready;
    assign in_meta_ready = out_meta_ready;

    ipv4_header_parser ipv4_header_parser_i (
        .in_pkt_data (in_pkt_data),
        .l3          (l3_fields.src)
    );

    l4_header_parser l4_header_parser_i (
        .in_pkt_data (in_pkt_data),
        .l4          (l4_fields.src)
    );

    meta_builder meta_builder_i (
        .clk            (clk),
        .rst            (rst),
        .l3             (l3_fields.dst),
        .l4             (l4_fields.dst),
        .in_pkt_valid   (in_pkt_valid),
        .in_pkt_sop     (in_pkt_sop),
        .in_pkt_eop     (in_pkt_eop),
        .in_meta_valid  (in_meta_valid),
        .in_meta_pkt_id (in_meta_pkt_id),
        .in_meta_flits  (in_meta_flits),
        .disable_pcie   (disable_pcie),
        .out_meta_ready (out_meta_ready),
        .out_meta_valid (out_meta_valid),
        .out_len        (out_len),
        .out_sip        (out_sip),
        .out_dip        (out_dip),
        .out_sport      (out_sport),
        .out_dport      (out_dport),
        .out_prot       (out_prot),
        .out_tcp_flags  (out_tcp_flags),
        .out_pkt_id     (out_pkt_id),
        .out_flits      (out_flits),
        .out_pcie       (out_pcie)
    );

endmodule

`default_nettype wire

/* meta_builder.sv */
`timescale 1ns/1ps
`default_nettype none

// Merges parsed header fields with the side-band descriptor into
// one registered metadata record
module meta_builder (
    input  logic                     clk,
    input  logic                     rst,
    l3_fields_if.dst                 l3,
    l4_fields_if.dst                 l4,
    input  logic                     in_pkt_valid,
    input  logic                     in_pkt_sop,
    input  logic                     in_pkt_eop,
    input  logic                     in_meta_valid,
    input  parser_pkg::pkt_id_t      in_meta_pkt_id,
    input  parser_pkg::flit_cnt_t    in_meta_flits,
    input  logic                     disable_pcie,
    input  logic                     out_meta_ready,
    output logic                     out_meta_valid,
    output parser_pkg::pkt_len_t     out_len,
    output parser_pkg::ip_addr_t     out_sip,
    output parser_pkg::ip_addr_t     out_dip,
    output parser_pkg::l4_port_t     out_sport,
    output parser_pkg::l4_port_t     out_dport,
    output parser_pkg::prot_code_t   out_prot,
    output parser_pkg::tcp_flags_t   out_tcp_flags,
    output parser_pkg::pkt_id_t      out_pkt_id,
    output parser_pkg::flit_cnt_t    out_flits,
    output logic                     out_pcie
);

    logic                   accept;
    logic [5:0]             ip_hdr_bytes;
    logic [5:0]             tcp_hdr_bytes;
    parser_pkg::pkt_len_t   l4_hdr_bytes;
    parser_pkg::pkt_len_t   payload_len;
    parser_pkg::prot_code_t prot_code;

    // Single-beat packet with its descriptor present
    assign accept = out_meta_ready && in_pkt_valid && in_pkt_sop && in_pkt_eop
                  && in_meta_valid;

    // Header lengths are counted in 32-bit words
    assign ip_hdr_bytes  = {l3.ihl, 2'b00};
    assign tcp_hdr_bytes = {l4.data_off, 2'b00};

    assign l4_hdr_bytes = l3.is_tcp ? {10'd0, tcp_hdr_bytes}
                                    : parser_pkg::pkt_len_t'(parser_pkg::UDP_HDR_BYTES);

    // Wraps modulo 2^16 on malformed lengths
    assign payload_len = l3.ip_len - {10'd0, ip_hdr_bytes} - l4_hdr_bytes;

    assign prot_code = !l3.supported ? parser_pkg::PROT_NS :
                       l3.is_tcp     ? parser_pkg::PROT_S_TCP :
                                       parser_pkg::PROT_S_UDP;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_meta_valid <= 1'b0;
        end else begin
            out_meta_valid <= accept;
        end
    end

    // Record fields only move on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            out_len       <= payload_len;
            out_sip       <= l3.sip;
            out_dip       <= l3.dip;
            out_sport     <= l4.sport;
            out_dport     <= l4.dport;
            out_prot      <= prot_code;
            out_tcp_flags <= l4.flags;
            out_pkt_id    <= in_meta_pkt_id;
            out_flits     <= in_meta_flits;
            out_pcie      <= !disable_pcie;
        end
    end

    // Every pulse traces back to an accept one cycle earlier
    a_valid_after_accept: assert property (
        @(posedge clk) disable iff (rst)
        out_meta_valid |-> $past(accept)
    ) else $error("out_meta_valid without a preceding accept");

    a_valid_low_after_reset: assert property (
        @(posedge clk) rst |=> !out_meta_valid
    ) else $error("out_meta_valid high right after reset");

endmodule

`default_nettype wire

/* l4_header_parser.sv */
`timescale 1ns/1ps
`default_nettype none

// TCP/UDP header extraction for a 20-byte IP header
module l4_header_parser (
    input  parser_pkg::pkt_data_t in_pkt_data,
    l4_fields_if.src              l4
);

    // L4 header starts right after the option-free IP header
    localparam int L4_BASE = 34;

    logic [15:0] sport;
    logic [15:0] dport;
    logic [3:0]  data_off;
    logic        flag_ns;
    logic [7:0]  flag_low;

    // Port positions are the same for TCP and UDP
    assign sport = in_pkt_data[parser_pkg::PKT_W-1-8*L4_BASE -: 16];
    assign dport = in_pkt_data[parser_pkg::PKT_W-1-8*(L4_BASE+2) -: 16];

    // Data offset, reserved bits and NS share TCP header byte 12
    assign data_off = in_pkt_data[parser_pkg::PKT_W-1-8*(L4_BASE+12) -: 4];
    assign flag_ns  = in_pkt_data[parser_pkg::PKT_W-8-8*(L4_BASE+12)];

    // CWR down to FIN in TCP header byte 13
    assign flag_low = in_pkt_data[parser_pkg::PKT_W-1-8*(L4_BASE+13) -: 8];

    assign l4.sport    = sport;
    assign l4.dport    = dport;
    assign l4.data_off = data_off;
    assign l4.flags    = {flag_ns, flag_low};

endmodule

`default_nettype wire

/* ipv4_header_parser.sv */
`timescale 1ns/1ps
`default_nettype none

// Ethernet type and IPv4 header extraction from a single beat.
// Frame byte 0 is the most significant byte of the beat.
module ipv4_header_parser (
    input  parser_pkg::pkt_data_t in_pkt_data,
    l3_fields_if.src              l3
);

    logic [15:0] eth_type;
    logic [3:0]  ip_version;
    logic [3:0]  ip_ihl;
    logic [15:0] ip_len;
    logic [7:0]  ip_prot;
    logic [31:0] ip_sip;
    logic [31:0] ip_dip;
    logic        prot_tcp;
    logic        prot_udp;

    // Bytes 12-13
    assign eth_type = in_pkt_data[parser_pkg::PKT_W-1-8*12 -: 16];

    // Byte 14 holds version in the upper nibble
    assign ip_version = in_pkt_data[parser_pkg::PKT_W-1-8*14 -: 4];
    assign ip_ihl     = in_pkt_data[parser_pkg::PKT_W-1-8*14-4 -: 4];

    // Total length at bytes 16-17
    assign ip_len = in_pkt_data[parser_pkg::PKT_W-1-8*16 -: 16];

    // Protocol at byte 23 between TTL and checksum
    assign ip_prot = in_pkt_data[parser_pkg::PKT_W-1-8*23 -: 8];

    // Addresses at bytes 26-29 and 30-33
    assign ip_sip = in_pkt_data[parser_pkg::PKT_W-1-8*26 -: 32];
    assign ip_dip = in_pkt_data[parser_pkg::PKT_W-1-8*30 -: 32];

    assign prot_tcp = (ip_prot == parser_pkg::IP_PROT_TCP);
    assign prot_udp = (ip_prot == parser_pkg::IP_PROT_UDP);

    // Only option-free IPv4 carrying TCP or UDP
    assign l3.supported = (eth_type == parser_pkg::ETH_TYPE_IPV4)
                        && (ip_version == parser_pkg::IP_V4)
                        && (ip_ihl == parser_pkg::IP_IHL_MIN)
                        && (prot_tcp || prot_udp);

    assign l3.is_tcp = prot_tcp;
    assign l3.ip_len = ip_len;
    assign l3.ihl    = ip_ihl;
    assign l3.sip    = ip_sip;
    assign l3.dip    = ip_dip;

endmodule

`default_nettype wire

/* l4_fields_if.sv */
`timescale 1ns/1ps
`default_nettype none

// TCP/UDP parser results toward the metadata builder
interface l4_fields_if;

    parser_pkg::l4_port_t   sport;
    parser_pkg::l4_port_t   dport;
    logic [3:0]             data_off;
    parser_pkg::tcp_flags_t flags;

    modport src (
        output sport, dport, data_off, flags
    );

    modport dst (
        input sport, dport, data_off, flags
    );

endinterface

`default_nettype wire

/* l3_fields_if.sv */
`timescale 1ns/1ps
`default_nettype none

// IPv4 parser results toward the metadata builder
interface l3_fields_if;

    logic                 supported;
    logic                 is_tcp;
    parser_pkg::pkt_len_t ip_len;
    logic [3:0]           ihl;
    parser_pkg::ip_addr_t sip;
    parser_pkg::ip_addr_t dip;

    modport src (
        output supported, is_tcp, ip_len, ihl, sip, dip
    );

    modport dst (
        input supported, is_tcp, ip_len, ihl, sip, dip
    );

endinterface

`default_nettype wire

/* parser_pkg.sv */
`default_nettype none

package parser_pkg;

    // Stream and side-band widths
    localparam int PKT_W    = 512;
    localparam int EMPTY_W  = 6;
    localparam int PKT_ID_W = 9;
    localparam int FLIT_W   = 5;

    // Header field values recognised by the parser
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [3:0]  IP_V4         = 4'd4;
    localparam logic [3:0]  IP_IHL_MIN    = 4'd5;
    localparam logic [7:0]  IP_PROT_TCP   = 8'd6;
    localparam logic [7:0]  IP_PROT_UDP   = 8'd17;

    // Fixed UDP header size in bytes
    localparam int UDP_HDR_BYTES = 8;

    typedef logic [PKT_W-1:0]    pkt_data_t;
    typedef logic [EMPTY_W-1:0]  pkt_empty_t;
    typedef logic [31:0]         ip_addr_t;
    typedef logic [15:0]         l4_port_t;
    typedef logic [15:0]         pkt_len_t;
    // NS, CWR, ECE, URG, ACK, PSH, RST, SYN, FIN from msb down
    typedef logic [8:0]          tcp_flags_t;
    typedef logic [PKT_ID_W-1:0] pkt_id_t;
    typedef logic [FLIT_W-1:0]   flit_cnt_t;

    // Protocol code reported with each record
    typedef logic [1:0] prot_code_t;

    localparam prot_code_t PROT_NS    = 2'd0;
    localparam prot_code_t PROT_S_TCP = 2'd1;
    localparam prot_code_t PROT_S_UDP = 2'd2;

endpackage

`default_nettype wire
